// ==== sources.f ====
verilog/cpu_pkg.sv
verilog/register_file.sv
verilog/con_ff.sv
verilog/datapath.sv
verilog/control_unit.sv
verilog/cpu_top.sv
test/cpu_checker.sv
test/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: bus_cpu

sources:
  - verilog/cpu_pkg.sv
  - verilog/register_file.sv
  - verilog/con_ff.sv
  - verilog/datapath.sv
  - verilog/control_unit.sv
  - verilog/cpu_top.sv
  - target: test
    files:
      - test/cpu_checker.sv
      - test/cpu_tb.sv

// ==== test/cpu_tb.sv ====
`timescale 1ns/100ps

module cpu_tb
    import cpu_pkg::*;
();

    localparam int num_rows      = 17;
    localparam int max_words     = 8;
    localparam int mem_words     = 256;
    localparam int fetch_timeout = 20;  // cycles, longest instruction is 8

    logic  clk;
    logic  reset;
    word_t mem_rdata;
    word_t mem_addr;
    logic  mem_read;

    word_t mem [mem_words];
    logic  read_seen = 1'b0;
    word_t read_addr;

    // stimulus table, one program and its fetch trace per row
    word_t prog     [num_rows][max_words];
    word_t exp_addr [num_rows][max_words];
    int    n_fetch  [num_rows];
    string row_name [num_rows];

    int    errors;
    int    checks;
    word_t rng;

    cpu_top #(
        .reset_vector (32'd0)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory answers a read during the cycle after the strobe
    always @(negedge clk) begin
        read_seen = (mem_read === 1'b1);
        read_addr = mem_addr;
    end

    always @(posedge clk) begin
        #1;
        if (read_seen)
            mem_rdata = mem[read_addr[7:0]];
    end

    function automatic word_t xorshift(input word_t x);
        word_t s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // op, ra, rb, 19-bit constant
    function automatic word_t encode(input opcode_t op, input int ra, input int rb,
                                     input word_t c);
        return {op, 4'(ra), 4'(rb), c[18:0]};
    endfunction

    function automatic word_t fill_word(input int addr);
        return {op_nop, 27'(addr)};     // still a nop
    endfunction

    task automatic new_row(input int r, input string name);
        row_name[r] = name;
        n_fetch[r] = 0;
        for (int i = 0; i < max_words; i++)
            prog[r][i] = fill_word(i);
    endtask

    task automatic add_fetch(input int r, input word_t addr);
        exp_addr[r][n_fetch[r]] = addr;
        n_fetch[r]++;
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic build_table();
        cond_t conds [8];
        word_t vals [8];
        bit    taken [8];
        string br_names [4];
        word_t c;
        word_t c1;
        word_t c2;
        int    r;
        conds = '{cond_zr, cond_zr, cond_nz, cond_nz, cond_pl, cond_pl, cond_mi, cond_mi};
        vals = '{32'd0, 32'd5, 32'd7, 32'd0, 32'd1, 32'hffff_ffff, 32'hffff_fffe, 32'd3};
        taken = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
        br_names = '{"brzr", "brnz", "brpl", "brmi"};
        r = 0;

        new_row(r, "nop_seq");
        for (int i = 0; i < 6; i++)
            add_fetch(r, i);
        r++;

        new_row(r, "unknown_op");
        prog[r][0] = {5'b11111, 27'h5a5a5a5};
        prog[r][1] = {5'b00000, 27'h0000123};
        prog[r][2] = {5'b01110, 27'h7ffffff};
        for (int i = 0; i < 5; i++)
            add_fetch(r, i);
        r++;

        // ldi r2, r0, c then jr r2
        for (int k = 0; k < 4; k++) begin
            if (k == 0) begin
                c = 32'h30;
            end else if (k == 1) begin
                c = 32'hffff_fffd;  // negative constant
            end else begin
                rng = xorshift(rng);
                c = 32'd8 + rng % 240;
            end
            new_row(r, $sformatf("ldi_jr_%0d", k));
            prog[r][0] = encode(op_ldi, 2, 0, c);
            prog[r][1] = encode(op_jr, 2, 0, '0);
            add_fetch(r, 0);
            add_fetch(r, 1);
            add_fetch(r, c);
            add_fetch(r, c + 1);
            r++;
        end

        // second ldi takes r2 as its base
        for (int k = 0; k < 2; k++) begin
            if (k == 0) begin
                c1 = 32'h50;
                c2 = 32'hffff_ffe0;
            end else begin
                rng = xorshift(rng);
                c1 = 32'd8 + rng % 120;
                rng = xorshift(rng);
                c2 = rng % 120;
            end
            new_row(r, $sformatf("ldi_ldi_jr_%0d", k));
            prog[r][0] = encode(op_ldi, 2, 0, c1);
            prog[r][1] = encode(op_ldi, 3, 2, c2);
            prog[r][2] = encode(op_jr, 3, 0, '0);
            add_fetch(r, 0);
            add_fetch(r, 1);
            add_fetch(r, 2);
            add_fetch(r, c1 + c2);
            add_fetch(r, c1 + c2 + 1);
            r++;
        end

        for (int k = 0; k < 8; k++) begin
            rng = xorshift(rng);
            c = 32'd8 + rng % 200;
            new_row(r, $sformatf("%s_%s", br_names[k / 2], taken[k] ? "taken" : "not"));
            prog[r][0] = encode(op_ldi, 5, 0, vals[k]);
            prog[r][1] = encode(op_br, 5, int'(conds[k]), c);
            add_fetch(r, 0);
            add_fetch(r, 1);
            add_fetch(r, taken[k] ? 32'd2 + c : 32'd2);
            add_fetch(r, taken[k] ? 32'd3 + c : 32'd3);
            r++;
        end

        // jal lands on a jr r15 at word 6
        new_row(r, "jal_link");
        prog[r][0] = encode(op_ldi, 4, 0, 32'd6);
        prog[r][1] = encode(op_jal, 4, 0, '0);
        prog[r][6] = encode(op_jr, 15, 0, '0);
        add_fetch(r, 0);
        add_fetch(r, 1);
        add_fetch(r, 6);
        add_fetch(r, 2);
        add_fetch(r, 3);
    endtask

    task automatic wait_fetch(output bit found, output word_t addr);
        found = 1'b0;
        addr = '0;
        for (int cyc = 0; cyc < fetch_timeout && !found; cyc++) begin
            @(negedge clk);
            if (mem_read === 1'b1) begin
                found = 1'b1;
                addr = mem_addr;
            end
        end
    endtask

    task automatic run_row(input int r);
        word_t got;
        bit    found;
        int    errs_before;
        errs_before = errors;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int a = 0; a < mem_words; a++)
            mem[a] = fill_word(a);
        for (int a = 0; a < max_words; a++)
            mem[a] = prog[r][a];
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int f = 0; f < n_fetch[r]; f++) begin
            wait_fetch(found, got);
            if (!found) begin
                errors++;
                $display("row %0d: fetch %0d never came within %0d cycles",
                         r, f, fetch_timeout);
                break;
            end
            check($sformatf("mem_addr[fetch %0d]", f), got, exp_addr[r][f]);
        end
        $display("row %0d %-16s %s", r, row_name[r], (errors == errs_before) ? "ok" : "bad");
    endtask

    initial begin
        reset = 1'b1;
        mem_rdata = '0;
        errors = 0;
        checks = 0;
        rng = 32'd67793;
        build_table();
        for (int r = 0; r < num_rows; r++)
            run_row(r);
        $display("rows %0d, checks %0d, errors %0d, assertion failures %0d",
                 num_rows, checks, errors, dut0.u_cpu_checker.fail_count);
        if (errors == 0 && dut0.u_cpu_checker.fail_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== test/cpu_checker.sv ====
`timescale 1ns/100ps

module cpu_checker import cpu_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  mem_read,
    input word_t mem_addr
);

    int fail_count = 0;     // failed assertions so far

    a_read_low_in_reset: assert property (@(posedge clk) reset |-> !mem_read)
        else begin
            $error("mem_read high while the cpu is held in reset");
            fail_count++;
        end

    a_read_one_cycle: assert property (@(posedge clk) disable iff (reset)
        mem_read |=> !mem_read)
        else begin
            $error("mem_read stayed high for two cycles");
            fail_count++;
        end

    // shortest instruction (nop) is four steps
    a_read_spacing: assert property (@(posedge clk) disable iff (reset)
        mem_read |=> !mem_read [*3])
        else begin
            $error("mem_read repeated within three cycles");
            fail_count++;
        end

    a_addr_known: assert property (@(posedge clk) disable iff (reset)
        mem_read |-> !$isunknown(mem_addr))
        else begin
            $error("mem_addr unknown during a read");
            fail_count++;
        end

endmodule

bind cpu_top cpu_checker u_cpu_checker (
    .clk      (clk),
    .reset    (reset),
    .mem_read (mem_read),
    .mem_addr (mem_addr)
);

// ==== verilog/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; #(
    parameter word_t reset_vector = '0
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t mem_rdata,
    output word_t mem_addr,
    output logic  mem_read
);

    opcode_t opcode;
    logic    con;
    logic    pc_out, zlow_out, mdr_out, c_out, r_out, ba_out;
    logic    pc_in, ir_in, mar_in, mdr_in, y_in, z_in, r_in, con_in;
    logic    gra, grb, link, inc_pc;

    control_unit u_control_unit (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .con      (con),
        .mem_read (mem_read),
        .pc_out   (pc_out),
        .zlow_out (zlow_out),
        .mdr_out  (mdr_out),
        .c_out    (c_out),
        .r_out    (r_out),
        .ba_out   (ba_out),
        .pc_in    (pc_in),
        .ir_in    (ir_in),
        .mar_in   (mar_in),
        .mdr_in   (mdr_in),
        .y_in     (y_in),
        .z_in     (z_in),
        .r_in     (r_in),
        .con_in   (con_in),
        .gra      (gra),
        .grb      (grb),
        .link     (link),
        .inc_pc   (inc_pc)
    );

    datapath #(
        .reset_vector (reset_vector)
    ) u_datapath (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .pc_out    (pc_out),
        .zlow_out  (zlow_out),
        .mdr_out   (mdr_out),
        .c_out     (c_out),
        .r_out     (r_out),
        .ba_out    (ba_out),
        .pc_in     (pc_in),
        .ir_in     (ir_in),
        .mar_in    (mar_in),
        .mdr_in    (mdr_in),
        .y_in      (y_in),
        .z_in      (z_in),
        .r_in      (r_in),
        .con_in    (con_in),
        .gra       (gra),
        .grb       (grb),
        .link      (link),
        .inc_pc    (inc_pc),
        .mem_addr  (mem_addr),
        .opcode    (opcode),
        .con       (con)
    );

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/100ps

module control_unit import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  opcode_t opcode,
    input  logic    con,
    output logic    mem_read,
    output logic    pc_out,
    output logic    zlow_out,
    output logic    mdr_out,
    output logic    c_out,
    output logic    r_out,
    output logic    ba_out,
    output logic    pc_in,
    output logic    ir_in,
    output logic    mar_in,
    output logic    mdr_in,
    output logic    y_in,
    output logic    z_in,
    output logic    r_in,
    output logic    con_in,
    output logic    gra,
    output logic    grb,
    output logic    link,
    output logic    inc_pc
);

    step_t step;
    step_t step_next;
    logic  done;    // last step of this instruction

    always_ff @(posedge clk) begin
        if (reset)
            step <= t0;
        else
            step <= step_next;
    end

    assign step_next = done ? t0 : step_t'(step + 3'd1);

    always_comb begin
        mem_read = 1'b0;
        pc_out   = 1'b0;
        zlow_out = 1'b0;
        mdr_out  = 1'b0;
        c_out    = 1'b0;
        r_out    = 1'b0;
        ba_out   = 1'b0;
        pc_in    = 1'b0;
        ir_in    = 1'b0;
        mar_in   = 1'b0;
        mdr_in   = 1'b0;
        y_in     = 1'b0;
        z_in     = 1'b0;
        r_in     = 1'b0;
        con_in   = 1'b0;
        gra      = 1'b0;
        grb      = 1'b0;
        link     = 1'b0;
        inc_pc   = 1'b0;
        done     = 1'b0;

        if (!reset) begin   // strobes stay low in reset
            case (step)
                t0: begin
                    pc_out = 1'b1;
                    mar_in = 1'b1;
                    inc_pc = 1'b1;
                    z_in   = 1'b1;      // z = pc + 1
                end
                t1: begin
                    zlow_out = 1'b1;
                    pc_in    = 1'b1;
                    mem_read = 1'b1;
                end
                t2: mdr_in = 1'b1;
                t3: begin
                    mdr_out = 1'b1;
                    ir_in   = 1'b1;
                    // nop and anything unknown stop here
                    done = !(opcode inside {op_ldi, op_br, op_jr, op_jal});
                end
                t4: begin
                    case (opcode)
                        op_ldi: begin
                            grb    = 1'b1;
                            ba_out = 1'b1;
                            y_in   = 1'b1;
                        end
                        op_br: begin
                            gra    = 1'b1;
                            r_out  = 1'b1;
                            con_in = 1'b1;
                        end
                        op_jr: begin
                            gra   = 1'b1;
                            r_out = 1'b1;
                            pc_in = 1'b1;
                            done  = 1'b1;
                        end
                        op_jal: begin
                            link   = 1'b1;
                            pc_out = 1'b1;
                            r_in   = 1'b1;  // r15 = return address
                        end
                        default: done = 1'b1;
                    endcase
                end
                t5: begin
                    case (opcode)
                        op_ldi: begin
                            c_out = 1'b1;
                            z_in  = 1'b1;
                        end
                        op_br: begin
                            pc_out = 1'b1;
                            y_in   = 1'b1;
                        end
                        op_jal: begin
                            gra   = 1'b1;
                            r_out = 1'b1;
                            pc_in = 1'b1;
                            done  = 1'b1;
                        end
                        default: done = 1'b1;
                    endcase
                end
                t6: begin
                    if (opcode == op_ldi) begin
                        zlow_out = 1'b1;
                        gra      = 1'b1;
                        r_in     = 1'b1;
                        done     = 1'b1;
                    end else begin
                        c_out = 1'b1;   // target = pc + c
                        z_in  = 1'b1;
                        done  = (opcode != op_br);
                    end
                end
                t7: begin
                    zlow_out = con;
                    pc_in    = con;     // taken only when con is set
                    done     = 1'b1;
                end
                default: done = 1'b1;
            endcase
        end
    end

endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/100ps

module datapath import cpu_pkg::*; #(
    parameter word_t reset_vector = '0
) (
    input  logic    clk,
    input  logic    reset,
    input  word_t   mem_rdata,
    // bus drivers
    input  logic    pc_out,
    input  logic    zlow_out,
    input  logic    mdr_out,
    input  logic    c_out,
    input  logic    r_out,
    input  logic    ba_out,
    // register loads
    input  logic    pc_in,
    input  logic    ir_in,
    input  logic    mar_in,
    input  logic    mdr_in,
    input  logic    y_in,
    input  logic    z_in,
    input  logic    r_in,
    input  logic    con_in,
    // selectors
    input  logic    gra,
    input  logic    grb,
    input  logic    link,
    input  logic    inc_pc,
    output word_t   mem_addr,
    output opcode_t opcode,
    output logic    con
);

    word_t pc;
    word_t ir;
    word_t mar;
    word_t mdr;
    word_t y;
    word_t z;
    word_t bus;
    word_t rdata;
    word_t c_sext;
    word_t sum;
    word_t ir_next;

    assign c_sext = {{(word_w-const_w){ir[const_msb]}}, ir[const_msb:0]};

    always_comb begin
        if (pc_out)
            bus = pc;
        else if (zlow_out)
            bus = z;
        else if (mdr_out)
            bus = mdr;
        else if (c_out)
            bus = c_sext;
        else if (r_out || ba_out)
            bus = rdata;
        else
            bus = '0;
    end

    // only add and increment are left of the alu
    assign sum = inc_pc ? bus + word_t'(1) : y + bus;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= reset_vector;
        else if (pc_in)
            pc <= bus;
    end

    always_ff @(posedge clk) begin
        if (ir_in)
            ir <= bus;
        if (mar_in)
            mar <= bus;
        if (mdr_in)
            mdr <= mem_rdata;   // word arrives the cycle after the read strobe
        if (y_in)
            y <= bus;
        if (z_in)
            z <= sum;
    end

    // opcode looks at the word being latched at t3 so the
    // control unit can choose its next step in the same cycle
    assign ir_next = ir_in ? bus : ir;
    assign opcode  = ir_next[op_msb:op_lsb];

    assign mem_addr = mar;

    register_file u_register_file (
        .clk    (clk),
        .reset  (reset),
        .ir     (ir),
        .gra    (gra),
        .grb    (grb),
        .link   (link),
        .r_in   (r_in),
        .r_out  (r_out),
        .ba_out (ba_out),
        .bus_in (bus),
        .rdata  (rdata)
    );

    con_ff u_con_ff (
        .clk    (clk),
        .reset  (reset),
        .ir     (ir),
        .bus_in (bus),
        .con_in (con_in),
        .con    (con)
    );

endmodule

// ==== verilog/con_ff.sv ====
`timescale 1ns/100ps

module con_ff import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t ir,
    input  word_t bus_in,
    input  logic  con_in,
    output logic  con
);

    cond_t cond;
    logic  cond_true;

    assign cond = ir[cond_msb:cond_lsb];

    always_comb begin
        case (cond)
            cond_zr: cond_true = (bus_in == '0);
            cond_nz: cond_true = (bus_in != '0);
            cond_pl: cond_true = ~bus_in[word_w-1];
            cond_mi: cond_true = bus_in[word_w-1];
            default: cond_true = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            con <= 1'b0;
        else if (con_in)
            con <= cond_true;
    end

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/100ps

module register_file import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t ir,
    input  logic  gra,
    input  logic  grb,
    input  logic  link,
    input  logic  r_in,
    input  logic  r_out,
    input  logic  ba_out,
    input  word_t bus_in,
    output word_t rdata
);

    word_t    regs [2**reg_w];
    reg_idx_t sel;

    always_comb begin
        if (link)
            sel = link_reg;
        else if (gra)
            sel = ir[ra_msb:ra_lsb];
        else if (grb)
            sel = ir[rb_msb:rb_lsb];
        else
            sel = '0;
    end

    always_comb begin
        if (ba_out && sel == '0)
            rdata = '0;         // base address path, r0 is zero
        else if (r_out || ba_out)
            rdata = regs[sel];
        else
            rdata = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_w; i++)
                regs[i] <= '0;
        end else if (r_in) begin
            regs[sel] <= bus_in;
        end
    end

endmodule

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    localparam int word_w  = 32;
    localparam int reg_w   = 4;
    localparam int op_w    = 5;
    localparam int cond_w  = 2;
    localparam int const_w = 19;

    typedef logic [word_w-1:0] word_t;
    typedef logic [reg_w-1:0]  reg_idx_t;
    typedef logic [op_w-1:0]   opcode_t;
    typedef logic [cond_w-1:0] cond_t;

    // instruction fields
    localparam int op_msb    = 31;
    localparam int op_lsb    = 27;
    localparam int ra_msb    = 26;
    localparam int ra_lsb    = 23;
    localparam int rb_msb    = 22;
    localparam int rb_lsb    = 19;
    localparam int cond_msb  = 20; // overlaps low bits of rb
    localparam int cond_lsb  = 19;
    localparam int const_msb = const_w - 1;

    // opcodes
    localparam opcode_t op_ldi = 5'b00001;
    localparam opcode_t op_br  = 5'b10011;
    localparam opcode_t op_jr  = 5'b10100;
    localparam opcode_t op_jal = 5'b10101;
    localparam opcode_t op_nop = 5'b11010;

    // branch conditions, tested against ra
    localparam cond_t cond_zr = 2'b00;
    localparam cond_t cond_nz = 2'b01;
    localparam cond_t cond_pl = 2'b10;
    localparam cond_t cond_mi = 2'b11;

    localparam reg_idx_t link_reg = 4'd15;

    // fetch is t0..t3, execute from t4
    typedef enum logic [2:0] {
        t0,
        t1,
        t2,
        t3,
        t4,
        t5,
        t6,
        t7
    } step_t;

endpackage
